// ==== source/conv_consts.svh ====
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Element and pixel geometry
`define CONV_BIT_WIDTH   8
`define CONV_NUM_CHANNEL 3
`define CONV_NUM_KERNEL  4
`define CONV_NUM_TAP     3

// Accumulation and line position widths
`define CONV_PSUM_WIDTH  16
`define CONV_POS_WIDTH   8

`endif

// ==== source/conv_data_pkg.sv ====
`default_nettype none
`include "conv_consts.svh"

package conv_data_pkg;

    // One signed activation or weight element
    typedef logic signed [`CONV_BIT_WIDTH-1:0] elem_t;

    // Channel 0 in the lowest bits
    typedef logic [`CONV_NUM_CHANNEL*`CONV_BIT_WIDTH-1:0] pixel_t;

    // Kernel-major, channel 0 lowest inside each kernel
    typedef logic [`CONV_NUM_KERNEL*`CONV_NUM_CHANNEL*`CONV_BIT_WIDTH-1:0] tap_weight_t;

    // Partial sums wrap at this width
    typedef logic signed [`CONV_PSUM_WIDTH-1:0] psum_t;

    // Kernel 0 in the lowest bits
    typedef logic [`CONV_NUM_KERNEL*`CONV_PSUM_WIDTH-1:0] kernel_psums_t;

endpackage

`default_nettype wire

// ==== source/conv_ctrl_pkg.sv ====
`default_nettype none
`include "conv_consts.svh"

package conv_ctrl_pkg;

    // Position inside a line, also used for the line width
    typedef logic [`CONV_POS_WIDTH-1:0] pos_t;

    typedef logic [1:0] tap_idx_t;

    typedef enum logic {
        WEIGHT_LOAD  = 1'b0,
        WEIGHT_READY = 1'b1
    } weight_state_t;

endpackage

`default_nettype wire

// ==== source/window_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

interface window_if;

    // Full three-pixel window present
    logic                                         win_valid;
    // Tap 0 holds the oldest pixel
    conv_data_pkg::pixel_t [`CONV_NUM_TAP-1:0]    win_pixels;
    // Window ends on the last pixel of the line
    logic                                         win_last;
    // Whole pipeline moves this cycle
    logic                                         advance;

    modport producer (
        output win_valid,
        output win_pixels,
        output win_last,
        input  advance
    );

    modport pe (
        input  win_pixels,
        input  advance
    );

    modport sink (
        input  win_valid,
        input  win_last,
        output advance
    );

endinterface

`default_nettype wire

// ==== source/weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module weight_store (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire                                            i_weight_valid,
    input  wire conv_data_pkg::tap_weight_t                i_weight_data,
    output logic                                           o_weight_ready,
    output conv_data_pkg::tap_weight_t [`CONV_NUM_TAP-1:0] o_tap_weights,
    output logic                                           o_loaded
);

    conv_ctrl_pkg::weight_state_t state;
    conv_ctrl_pkg::tap_idx_t      tap_idx;
    logic                         weight_take;

    assign o_weight_ready = (state == conv_ctrl_pkg::WEIGHT_LOAD);
    assign o_loaded       = (state == conv_ctrl_pkg::WEIGHT_READY);
    assign weight_take    = i_weight_valid & o_weight_ready;

    ////////////////////
    // Load sequencing
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= conv_ctrl_pkg::WEIGHT_LOAD;
            tap_idx <= '0;
        end else if (weight_take) begin
            if (tap_idx == conv_ctrl_pkg::tap_idx_t'(`CONV_NUM_TAP - 1)) begin
                // Last tap in, weights stay until the next reset
                state   <= conv_ctrl_pkg::WEIGHT_READY;
                tap_idx <= '0;
            end else begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

    // Taps arrive in order, the counter picks the slot
    always_ff @(posedge clk) begin
        if (weight_take) begin
            o_tap_weights[tap_idx] <= i_weight_data;
        end
    end

    tap_idx_range: assert property (
        @(posedge clk) disable iff (rst)
        tap_idx <= conv_ctrl_pkg::tap_idx_t'(`CONV_NUM_TAP - 1)
    ) else $error("weight_store: tap counter at %0d", tap_idx);

endmodule

`default_nettype wire

// ==== source/pixel_window.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module pixel_window (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_pixel_valid,
    input  wire conv_data_pkg::pixel_t   i_pixel_data,
    output logic                         o_pixel_ready,
    input  wire conv_ctrl_pkg::pos_t     i_line_width,
    input  wire                          i_loaded,
    window_if.producer                   win
);

    conv_ctrl_pkg::pos_t pos;
    logic                pixel_take;
    logic                pos_at_end;

    // Ready only once weights are in and the pipeline moves
    assign o_pixel_ready = i_loaded & win.advance;
    assign pixel_take    = i_pixel_valid & o_pixel_ready;
    assign pos_at_end    = (pos == i_line_width - 1'b1);

    ////////////////////
    // Line position
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pos           <= '0;
            win.win_valid <= 1'b0;
            win.win_last  <= 1'b0;
        end else if (pixel_take) begin
            pos           <= pos_at_end ? '0 : pos + 1'b1;
            // Window is full from the third pixel of a line on
            win.win_valid <= (pos >= conv_ctrl_pkg::pos_t'(`CONV_NUM_TAP - 1));
            win.win_last  <= pos_at_end;
        end else if (win.advance) begin
            // No pixel this cycle, send a bubble down
            win.win_valid <= 1'b0;
            win.win_last  <= 1'b0;
        end
    end

    ////////////////////
    // Window shift
    ////////////////////
    // Newest pixel enters at the top tap, oldest drops out of tap 0
    always_ff @(posedge clk) begin
        if (pixel_take) begin
            win.win_pixels <= {i_pixel_data, win.win_pixels[`CONV_NUM_TAP-1:1]};
        end
    end

    pos_in_line: assert property (
        @(posedge clk) disable iff (rst)
        pos < i_line_width
    ) else $error("pixel_window: position %0d outside line width %0d", pos, i_line_width);

endmodule

`default_nettype wire

// ==== source/kc_pe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module kc_pe #(
    parameter conv_ctrl_pkg::tap_idx_t TAP = 2'd0
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire conv_data_pkg::tap_weight_t   i_tap_weights,
    output conv_data_pkg::kernel_psums_t      o_kernel_psums,
    window_if.pe                              win
);

    conv_data_pkg::pixel_t        tap_pixel;
    conv_data_pkg::kernel_psums_t mac_sum;

    assign tap_pixel = win.win_pixels[TAP];

    // Channel MAC for every kernel, products kept at psum width
    always_comb begin
        conv_data_pkg::elem_t pix;
        conv_data_pkg::elem_t wgt;
        conv_data_pkg::psum_t prod;
        conv_data_pkg::psum_t acc;
        mac_sum = '0;
        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            acc = '0;
            for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                pix  = tap_pixel[c*`CONV_BIT_WIDTH +: `CONV_BIT_WIDTH];
                wgt  = i_tap_weights[(k*`CONV_NUM_CHANNEL + c)*`CONV_BIT_WIDTH +: `CONV_BIT_WIDTH];
                prod = pix * wgt;
                acc  = acc + prod;
            end
            mac_sum[k*`CONV_PSUM_WIDTH +: `CONV_PSUM_WIDTH] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_kernel_psums <= '0;
        end else if (win.advance) begin
            o_kernel_psums <= mac_sum;
        end
    end

endmodule

`default_nettype wire

// ==== source/psum_output.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module psum_output (
    input  wire                                                 clk,
    input  wire                                                 rst,
    input  wire conv_data_pkg::kernel_psums_t [`CONV_NUM_TAP-1:0] i_tap_psums,
    output logic                                                o_psum_valid,
    output conv_data_pkg::kernel_psums_t                        o_psum_data,
    output logic                                                o_psum_last,
    input  wire                                                 i_psum_ready,
    window_if.sink                                              win
);

    logic                         pe_valid;
    logic                         pe_last;
    conv_data_pkg::kernel_psums_t tap_sum;

    // Every stage moves unless a result is stuck at the output
    assign win.advance = ~o_psum_valid | i_psum_ready;

    // Per-kernel sum over taps, wraps at psum width
    always_comb begin
        conv_data_pkg::psum_t acc;
        tap_sum = '0;
        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            acc = '0;
            for (int t = 0; t < `CONV_NUM_TAP; t++) begin
                acc = acc + i_tap_psums[t][k*`CONV_PSUM_WIDTH +: `CONV_PSUM_WIDTH];
            end
            tap_sum[k*`CONV_PSUM_WIDTH +: `CONV_PSUM_WIDTH] = acc;
        end
    end

    ////////////////////
    // Control pipeline
    ////////////////////
    // pe_* lines up with the PE registers
    always_ff @(posedge clk) begin
        if (rst) begin
            pe_valid     <= 1'b0;
            pe_last      <= 1'b0;
            o_psum_valid <= 1'b0;
            o_psum_last  <= 1'b0;
        end else if (win.advance) begin
            pe_valid     <= win.win_valid;
            pe_last      <= win.win_last;
            o_psum_valid <= pe_valid;
            o_psum_last  <= pe_last;
        end
    end

    always_ff @(posedge clk) begin
        if (win.advance) begin
            o_psum_data <= tap_sum;
        end
    end

    held_result_stable: assert property (
        @(posedge clk) disable iff (rst)
        (o_psum_valid && !i_psum_ready) |=> ($stable(o_psum_data) && $stable(o_psum_last))
    ) else $error("psum_output: result changed while stalled");

endmodule

`default_nettype wire

// ==== source/line_conv_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module line_conv_engine (
    input  wire                               clk,
    input  wire                               rst,
    // Weight load
    input  wire                               i_weight_valid,
    output logic                              o_weight_ready,
    input  wire conv_data_pkg::tap_weight_t   i_weight_data,
    // Pixel stream
    input  wire                               i_pixel_valid,
    output logic                              o_pixel_ready,
    input  wire conv_data_pkg::pixel_t        i_pixel_data,
    // Results
    output logic                              o_psum_valid,
    input  wire                               i_psum_ready,
    output conv_data_pkg::kernel_psums_t      o_psum_data,
    output logic                              o_psum_last,
    // Held stable for the whole run
    input  wire conv_ctrl_pkg::pos_t          i_line_width
);

    conv_data_pkg::tap_weight_t   [`CONV_NUM_TAP-1:0] tap_weights;
    conv_data_pkg::kernel_psums_t [`CONV_NUM_TAP-1:0] tap_psums;
    logic                                             weights_loaded;

    window_if win_bus ();

    weight_store u_weight_store (
        .clk            (clk),
        .rst            (rst),
        .i_weight_valid (i_weight_valid),
        .i_weight_data  (i_weight_data),
        .o_weight_ready (o_weight_ready),
        .o_tap_weights  (tap_weights),
        .o_loaded       (weights_loaded)
    );

    pixel_window u_pixel_window (
        .clk           (clk),
        .rst           (rst),
        .i_pixel_valid (i_pixel_valid),
        .i_pixel_data  (i_pixel_data),
        .o_pixel_ready (o_pixel_ready),
        .i_line_width  (i_line_width),
        .i_loaded      (weights_loaded),
        .win           (win_bus.producer)
    );

    // One PE per tap
    for (genvar t = 0; t < `CONV_NUM_TAP; t++) begin : g_pe
        kc_pe #(
            .TAP (conv_ctrl_pkg::tap_idx_t'(t))
        ) u_kc_pe (
            .clk            (clk),
            .rst            (rst),
            .i_tap_weights  (tap_weights[t]),
            .o_kernel_psums (tap_psums[t]),
            .win            (win_bus.pe)
        );
    end

    psum_output u_psum_output (
        .clk          (clk),
        .rst          (rst),
        .i_tap_psums  (tap_psums),
        .o_psum_valid (o_psum_valid),
        .o_psum_data  (o_psum_data),
        .o_psum_last  (o_psum_last),
        .i_psum_ready (i_psum_ready),
        .win          (win_bus.sink)
    );

endmodule

`default_nettype wire

// ==== test/tb_line_conv_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_consts.svh"

module tb_line_conv_engine;

    logic                         clk;
    logic                         rst;
    logic                         i_weight_valid;
    logic                         o_weight_ready;
    conv_data_pkg::tap_weight_t   i_weight_data;
    logic                         i_pixel_valid;
    logic                         o_pixel_ready;
    conv_data_pkg::pixel_t        i_pixel_data;
    logic                         o_psum_valid;
    logic                         i_psum_ready;
    conv_data_pkg::kernel_psums_t o_psum_data;
    logic                         o_psum_last;
    conv_ctrl_pkg::pos_t          i_line_width;

    logic [95:0]                  test_mem [0:63];
    int                           line_width;
    int                           num_pixels;
    int                           num_results;
    int                           exp_base;
    int                           cycle_limit;
    int                           cycles;
    int                           weights_sent;
    int                           pixels_sent;
    int                           results_seen;
    int                           line_results;
    logic                         w_xfer;
    logic                         p_xfer;
    logic                         r_xfer;
    logic                         held;
    logic                         held_last;
    conv_data_pkg::kernel_psums_t held_data;
    logic [31:0]                  rng;

    line_conv_engine i_dut (
        .clk            (clk),
        .rst            (rst),
        .i_weight_valid (i_weight_valid),
        .o_weight_ready (o_weight_ready),
        .i_weight_data  (i_weight_data),
        .i_pixel_valid  (i_pixel_valid),
        .o_pixel_ready  (o_pixel_ready),
        .i_pixel_data   (i_pixel_data),
        .o_psum_valid   (o_psum_valid),
        .i_psum_ready   (i_psum_ready),
        .o_psum_data    (o_psum_data),
        .o_psum_last    (o_psum_last),
        .i_line_width   (i_line_width)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [95:0] actual,
                               input logic [95:0] expected);
        if (actual !== expected) begin
            $display("error: %0t %s got %0h expected %0h", $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Compare one accepted result with its file entry
    task automatic compare_result(input int idx);
        logic [95:0]          exp_word;
        conv_data_pkg::psum_t got_psum;
        conv_data_pkg::psum_t exp_psum;
        exp_word = test_mem[exp_base + idx];
        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            got_psum = o_psum_data[k*`CONV_PSUM_WIDTH +: `CONV_PSUM_WIDTH];
            exp_psum = exp_word[k*`CONV_PSUM_WIDTH +: `CONV_PSUM_WIDTH];
            check_value($sformatf("o_psum_data kernel %0d", k), got_psum, exp_psum);
        end
        check_value("o_psum_last", o_psum_last, exp_word[`CONV_NUM_KERNEL*`CONV_PSUM_WIDTH]);
    endtask

    ////////////////////
    // Mid-cycle sampling
    ////////////////////
    task automatic sample_outputs();
        check_value("o_weight_ready", o_weight_ready, weights_sent < `CONV_NUM_TAP);
        if (weights_sent < `CONV_NUM_TAP)
            check_value("o_pixel_ready", o_pixel_ready, 1'b0);
        // No full window yet
        if (pixels_sent < `CONV_NUM_TAP)
            check_value("o_psum_valid", o_psum_valid, 1'b0);
        if (held) begin
            check_value("o_psum_valid", o_psum_valid, 1'b1);
            check_value("o_psum_data", o_psum_data, held_data);
            check_value("o_psum_last", o_psum_last, held_last);
        end
        w_xfer = i_weight_valid & o_weight_ready;
        p_xfer = i_pixel_valid & o_pixel_ready;
        r_xfer = o_psum_valid & i_psum_ready;
        if (r_xfer) begin
            compare_result(results_seen);
            results_seen++;
            line_results++;
            if (o_psum_last) begin
                check_value("results in line", line_results, line_width - 2);
                line_results = 0;
            end
        end
        held      = o_psum_valid & ~i_psum_ready;
        held_data = o_psum_data;
        held_last = o_psum_last;
    endtask

    // Valid stays up until taken
    // Gaps and stalls come from the xorshift
    task automatic drive_inputs();
        if (w_xfer)
            weights_sent++;
        if (p_xfer)
            pixels_sent++;
        rng = xorshift32(rng);
        if (weights_sent >= `CONV_NUM_TAP) begin
            i_weight_valid = 1'b0;
        end else if (!i_weight_valid || w_xfer) begin
            i_weight_valid = (rng[1:0] != 2'b00);
            i_weight_data  = test_mem[2 + weights_sent];
        end
        if (pixels_sent >= num_pixels) begin
            i_pixel_valid = 1'b0;
        end else if (!i_pixel_valid || p_xfer) begin
            i_pixel_valid = (rng[3:2] != 2'b00);
            i_pixel_data  = conv_data_pkg::pixel_t'(test_mem[2 + `CONV_NUM_TAP + pixels_sent]);
        end
        i_psum_ready = rng[4];
    endtask

    initial begin
        $readmemh("test/conv_tests.txt", test_mem);
        line_width     = int'(test_mem[0]);
        num_pixels     = line_width * int'(test_mem[1]);
        num_results    = int'(test_mem[1]) * (line_width - 2);
        exp_base       = 2 + `CONV_NUM_TAP + num_pixels;
        cycle_limit    = 20 * (`CONV_NUM_TAP + num_pixels) + 100;
        rst            = 1'b1;
        i_weight_valid = 1'b0;
        i_weight_data  = '0;
        i_pixel_valid  = 1'b0;
        i_pixel_data   = '0;
        i_psum_ready   = 1'b0;
        i_line_width   = conv_ctrl_pkg::pos_t'(line_width);
        rng            = 32'd95;
        cycles         = 0;
        weights_sent   = 0;
        pixels_sent    = 0;
        results_seen   = 0;
        line_results   = 0;
        held           = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        while (results_seen < num_results) begin
            @(negedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout: only %0d of %0d results after %0d cycles",
                         results_seen, num_results, cycles);
                $display("Simulation finished: FAIL");
                $fatal(1, "timeout");
            end
            sample_outputs();
            @(posedge clk);
            #1;
            drive_inputs();
        end
        // Nothing more may come out
        i_psum_ready = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_value("o_psum_valid", o_psum_valid, 1'b0);
        end
        if (weights_sent == `CONV_NUM_TAP && pixels_sent == num_pixels) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Stimulus not fully used: %0d weights and %0d pixels sent",
                     weights_sent, pixels_sent);
            $display("Simulation finished: FAIL");
            $fatal(1, "incomplete run");
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/conv_data_pkg.sv
source/conv_ctrl_pkg.sv
source/window_if.sv
source/weight_store.sv
source/pixel_window.sv
source/kc_pe.sv
source/psum_output.sv
source/line_conv_engine.sv
test/tb_line_conv_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_line_conv_engine -f flist.f -o tb_sim
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Run ended without a result, see sim.log"
    exit 1
fi

// ==== test/conv_tests.txt ====
// One hex word per line: line width, line count, tap 0..2 weight words,
// then pixels {c2,c1,c0}, then expected results {last, psum k3, k2, k1, k0}
5
2
// Weights, kernel 3 is all -128 so its sums wrap
808080ff0200000001010101
808080ff0200000002010101
808080ff0200000003010101
// Line 0 pixels
030201
fe04ff
07fb0a
646464
808080
// Line 1 pixels
808080
808080
808080
7f7f7f
fd0005
// Expected results for line 0
0_f680_fffa_001d_0013
0_6380_005d_013f_0139
1_2400_ffd3_ff52_ffb8
// Expected results for line 1
0_4000_fe80_fd00_fb80
0_c180_ff7f_fffd_fe7d
1_0080_0002_008d_ffff
